/* Makefile */
VERILATOR ?= verilator
TOP       := tb_output_port_lookup
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only -Wall --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* eth_parser.sv */
`include "oplut_defs.svh"

module eth_parser (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic [`OPLUT_DATA_W-1:0] in_data,
   input  pkt_pkg::hdr_word_e       word_pos,
   input  logic                     accept,
   input  regs_pkg::mac_table_t     mac_table,
   output pkt_pkg::eth_result_t     eth_result
);
   logic [47:0]              dst_mac;
   logic                     is_bcast;
   logic                     hit;
   logic [`OPLUT_PORT_W-1:0] hit_idx;

   assign dst_mac  = in_data[63:16];   // first six bytes of the frame
   assign is_bcast = &dst_mac;

   // priority match, lowest index wins so scan downwards
   always_comb begin
      hit     = 1'b0;
      hit_idx = '0;
      for (int i = `OPLUT_NUM_PORTS - 1; i >= 0; i--) begin
         if (dst_mac == mac_table[i]) begin
            hit     = 1'b1;
            hit_idx = i[`OPLUT_PORT_W-1:0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         eth_result <= '0;
      end else if (accept) begin
         if (word_pos == pkt_pkg::HDR_W0) begin
            eth_result.mac_hit <= hit && !is_bcast;   // broadcast never matches
            eth_result.port    <= hit_idx;
         end
         if (word_pos == pkt_pkg::HDR_W1) begin
            eth_result.is_ip <= (in_data[31:16] == `OPLUT_ETHERTYPE_IP);
         end
      end
   end

endmodule

/* forward_ctrl.sv */
`include "oplut_defs.svh"

module forward_ctrl (
   input  logic                    clk,
   input  logic                    rst_n,
   input  pkt_pkg::pkt_word_t      pkt_head,
   input  logic                    pkt_empty,
   output logic                    pkt_rd,
   input  pkt_pkg::lookup_result_t res_head,
   input  logic                    res_empty,
   output logic                    res_rd,
   output pkt_pkg::out_pkt_t       out_pkt,
   output logic                    out_valid,
   input  logic                    out_ready,
   output regs_pkg::stats_pulse_t  stats
);
   typedef enum logic [1:0] {IDLE, FORWARD, DROP} state_e;

   state_e                   state;
   pkt_pkg::verdict_e        verdict;      // decision for the result at the head
   pkt_pkg::verdict_e        verdict_q;    // decision for the packet in flight
   logic [`OPLUT_PORT_W-1:0] port_q;
   logic [15:0]              csum_q;
   logic [2:0]               word_cnt;     // saturates at 4, only words 2 and 3 matter
   logic [`OPLUT_DATA_W-1:0] out_data;
   logic                     pop_last;

   // ========================================
   // verdict, first failing check wins
   // ========================================
   always_comb begin
      if (!res_head.eth.mac_hit)       verdict = pkt_pkg::VERDICT_DROP_MAC;
      else if (!res_head.eth.is_ip)    verdict = pkt_pkg::VERDICT_DROP_NON_IP;
      else if (!res_head.ip.hdr_good)  verdict = pkt_pkg::VERDICT_DROP_HDR;
      else if (!res_head.ip.ttl_good)  verdict = pkt_pkg::VERDICT_DROP_TTL;
      else                             verdict = pkt_pkg::VERDICT_FWD;
   end

   assign res_rd    = (state == IDLE) && !res_empty;      // one result per packet
   assign out_valid = (state == FORWARD) && !pkt_empty;   // stable, head only moves on pop
   assign pkt_rd    = (state == FORWARD) ? (out_valid && out_ready)
                                         : ((state == DROP) && !pkt_empty);   // drops ignore out_ready
   assign pop_last  = pkt_rd && pkt_head.last;

   // header rewrite on the way out
   always_comb begin
      out_data = pkt_head.data;
      if (word_cnt == 3'd2) out_data[15:8]  = pkt_head.data[15:8] - 8'd1;   // ttl
      if (word_cnt == 3'd3) out_data[63:48] = csum_q;                       // ip checksum
      out_pkt = '{port: port_q, word: '{data: out_data, last: pkt_head.last}};
   end

   always_comb begin
      stats.forwarded  = (state == FORWARD) && pop_last;
      stats.drop_hdr   = (state == DROP) && pop_last && (verdict_q == pkt_pkg::VERDICT_DROP_HDR);
      stats.drop_other = (state == DROP) && pop_last && (verdict_q != pkt_pkg::VERDICT_DROP_HDR);
   end

   // ========================================
   // FSM
   // ========================================
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= IDLE;
         verdict_q <= pkt_pkg::VERDICT_FWD;
         port_q    <= '0;
         csum_q    <= '0;
         word_cnt  <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (res_rd) begin
                  verdict_q <= verdict;
                  port_q    <= res_head.eth.port;
                  csum_q    <= res_head.ip.new_checksum;
                  word_cnt  <= '0;
                  state     <= (verdict == pkt_pkg::VERDICT_FWD) ? FORWARD : DROP;
               end
            end
            FORWARD: begin
               if (pop_last) state <= IDLE;
               else if (pkt_rd && word_cnt != 3'd4) word_cnt <= word_cnt + 3'd1;
            end
            DROP: if (pop_last) state <= IDLE;   // flush the whole packet
            default: state <= IDLE;
         endcase
      end
   end

endmodule

/* hdr_word_tracker.sv */
module hdr_word_tracker (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              in_valid,
   input  logic              in_ready,
   input  logic              in_last,
   output pkt_pkg::hdr_word_e word_pos,
   output logic              hdr_done
);
   logic accept;

   assign accept   = in_valid && in_ready;
   assign hdr_done = accept && (word_pos == pkt_pkg::HDR_W4);   // lookup result complete

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         word_pos <= pkt_pkg::HDR_W0;
      end else if (accept) begin
         if (in_last) begin
            word_pos <= pkt_pkg::HDR_W0;   // next word starts a new packet
         end else if (word_pos != pkt_pkg::HDR_PAYLOAD) begin
            word_pos <= pkt_pkg::hdr_word_e'(word_pos + 3'd1);
         end
      end
   end

endmodule

/* ip_header_checker.sv */
`include "oplut_defs.svh"

module ip_header_checker (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic [`OPLUT_DATA_W-1:0] in_data,
   input  pkt_pkg::hdr_word_e       word_pos,
   input  logic                     accept,
   output pkt_pkg::ip_result_t      ip_result
);
   logic [19:0] sum_acc;     // raw sum of nine fields fits in 20 bits
   logic [15:0] rx_csum;
   logic [7:0]  ttl;
   logic [7:0]  ver_ihl;
   logic [19:0] sum_all;     // header sum with dst ip lo, checksum excluded
   logic [20:0] sum_chk;

   // end-around carry fold down to 16 bits
   function automatic logic [15:0] fold16(input logic [20:0] s);
      logic [16:0] t;
      t      = {12'h0, s[20:16]} + s[15:0];
      fold16 = t[15:0] + {15'h0, t[16]};
   endfunction

   assign sum_all = sum_acc + 20'(in_data[63:48]);   // word 4 adds dst ip lo
   assign sum_chk = 21'(sum_all) + 21'(rx_csum);

   // valid only while word 4 is on the input
   always_comb begin
      ip_result.hdr_good     = (ver_ihl == 8'h45) && (fold16(sum_chk) == 16'hFFFF);
      ip_result.ttl_good     = (ttl >= 8'(`OPLUT_TTL_MIN));
      ip_result.new_checksum = ~fold16(21'(sum_all - 20'h00100));   // ttl field minus one
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sum_acc <= '0;
         rx_csum <= '0;
         ttl     <= '0;
         ver_ihl <= '0;
      end else if (accept) begin
         case (word_pos)
            pkt_pkg::HDR_W1: begin
               sum_acc <= 20'(in_data[15:0]);   // ver/ihl and tos, restarts the sum
               ver_ihl <= in_data[15:8];
            end
            pkt_pkg::HDR_W2: begin
               sum_acc <= sum_acc + 20'(in_data[63:48]) + 20'(in_data[47:32])
                          + 20'(in_data[31:16]) + 20'(in_data[15:0]);
               ttl     <= in_data[15:8];
            end
            pkt_pkg::HDR_W3: begin
               rx_csum <= in_data[63:48];       // kept apart from the sum
               sum_acc <= sum_acc + 20'(in_data[47:32]) + 20'(in_data[31:16])
                          + 20'(in_data[15:0]);
            end
            default: ;
         endcase
      end
   end

endmodule

/* oplut_defs.svh */
`ifndef OPLUT_DEFS_SVH
`define OPLUT_DEFS_SVH

// ========================================
// datapath sizes
// ========================================
`define OPLUT_DATA_W         64        // stream word width
`define OPLUT_NUM_PORTS      4         // port MAC entries
`define OPLUT_PORT_W         2         // port index width
`define OPLUT_PKT_FIFO_BITS  5         // 32 word packet buffer
`define OPLUT_RES_FIFO_BITS  3         // 8 lookup results

// protocol constants
`define OPLUT_ETHERTYPE_IP   16'h0800
`define OPLUT_TTL_MIN        2         // ttl 0 and 1 are not forwarded

// ========================================
// register map
// ========================================
`define OPLUT_REG_ADDR_W     4
`define OPLUT_REG_MAC0_HI    4'd0      // hi word holds mac[47:32]
`define OPLUT_REG_MAC0_LO    4'd1      // lo word holds mac[31:0]
`define OPLUT_REG_MAC1_HI    4'd2
`define OPLUT_REG_MAC1_LO    4'd3
`define OPLUT_REG_MAC2_HI    4'd4
`define OPLUT_REG_MAC2_LO    4'd5
`define OPLUT_REG_MAC3_HI    4'd6
`define OPLUT_REG_MAC3_LO    4'd7
`define OPLUT_REG_FORWARDED  4'd8      // read only counters
`define OPLUT_REG_DROP_HDR   4'd9
`define OPLUT_REG_DROP_OTHER 4'd10

`endif

/* oplut_regs.sv */
`include "oplut_defs.svh"

module oplut_regs (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   reg_req_valid,
   input  regs_pkg::reg_req_t     reg_req,
   output logic                   reg_ack,
   output regs_pkg::reg_rsp_t     reg_rsp,
   input  regs_pkg::stats_pulse_t stats,
   output regs_pkg::mac_table_t   mac_table
);
   logic [31:0]              fwd_cnt;
   logic [31:0]              drop_hdr_cnt;
   logic [31:0]              drop_other_cnt;
   logic [`OPLUT_PORT_W-1:0] mac_idx;

   assign mac_idx = reg_req.addr[`OPLUT_PORT_W:1];   // hi/lo pairs, two addresses per port

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         reg_ack        <= 1'b0;
         reg_rsp        <= '0;
         mac_table      <= '0;
         fwd_cnt        <= '0;
         drop_hdr_cnt   <= '0;
         drop_other_cnt <= '0;
      end else begin
         reg_ack <= reg_req_valid;   // ack always one cycle later
         reg_rsp <= '0;              // zero outside the ack cycle and for writes

         fwd_cnt        <= fwd_cnt + 32'(stats.forwarded);
         drop_hdr_cnt   <= drop_hdr_cnt + 32'(stats.drop_hdr);
         drop_other_cnt <= drop_other_cnt + 32'(stats.drop_other);

         if (reg_req_valid) begin
            case (reg_req.addr)
               `OPLUT_REG_MAC0_HI, `OPLUT_REG_MAC1_HI, `OPLUT_REG_MAC2_HI, `OPLUT_REG_MAC3_HI: begin
                  if (reg_req.wr) mac_table[mac_idx][47:32] <= reg_req.data[15:0];
                  else reg_rsp.rd_data <= {16'h0, mac_table[mac_idx][47:32]};
               end
               `OPLUT_REG_MAC0_LO, `OPLUT_REG_MAC1_LO, `OPLUT_REG_MAC2_LO, `OPLUT_REG_MAC3_LO: begin
                  if (reg_req.wr) mac_table[mac_idx][31:0] <= reg_req.data;
                  else reg_rsp.rd_data <= mac_table[mac_idx][31:0];
               end
               `OPLUT_REG_FORWARDED:  if (!reg_req.wr) reg_rsp.rd_data <= fwd_cnt;
               `OPLUT_REG_DROP_HDR:   if (!reg_req.wr) reg_rsp.rd_data <= drop_hdr_cnt;
               `OPLUT_REG_DROP_OTHER: if (!reg_req.wr) reg_rsp.rd_data <= drop_other_cnt;
               default: ;   // unmapped, reads back 0
            endcase
         end
      end
   end

endmodule

/* output_port_lookup.sv */
`include "oplut_defs.svh"

module output_port_lookup (
   input  logic                   clk,
   input  logic                   rst_n,
   input  pkt_pkg::pkt_word_t     in_word,
   input  logic                   in_valid,
   output logic                   in_ready,
   output pkt_pkg::out_pkt_t      out_pkt,
   output logic                   out_valid,
   input  logic                   out_ready,
   input  logic                   reg_req_valid,
   input  regs_pkg::reg_req_t     reg_req,
   output logic                   reg_ack,
   output regs_pkg::reg_rsp_t     reg_rsp
);
   logic                    in_accept;
   logic                    pkt_nearly_full;
   pkt_pkg::pkt_word_t      pkt_head;
   logic                    pkt_empty, pkt_rd;
   pkt_pkg::lookup_result_t res_wr, res_head;
   logic                    res_empty, res_rd;
   pkt_pkg::hdr_word_e      word_pos;
   logic                    hdr_done;
   pkt_pkg::eth_result_t    eth_result;
   pkt_pkg::ip_result_t     ip_result;
   regs_pkg::mac_table_t    mac_table;
   regs_pkg::stats_pulse_t  stats;

   assign in_ready  = !pkt_nearly_full;       // two words of slack in the buffer
   assign in_accept = in_valid && in_ready;
   assign res_wr    = '{eth: eth_result, ip: ip_result};

   // ========================================
   // buffering, snoop path and FSM
   // ========================================
   sync_fifo #(.WIDTH($bits(pkt_pkg::pkt_word_t)), .DEPTH_BITS(`OPLUT_PKT_FIFO_BITS)) pkt_fifo (
      .clk(clk), .rst_n(rst_n), .wr_data(in_word), .wr_en(in_accept), .rd_en(pkt_rd),
      .rd_data(pkt_head), .empty(pkt_empty), .nearly_full(pkt_nearly_full));

   sync_fifo #(.WIDTH($bits(pkt_pkg::lookup_result_t)), .DEPTH_BITS(`OPLUT_RES_FIFO_BITS)) res_fifo (
      .clk(clk), .rst_n(rst_n), .wr_data(res_wr), .wr_en(hdr_done), .rd_en(res_rd),
      .rd_data(res_head), .empty(res_empty), .nearly_full());   // sized for worst case

   hdr_word_tracker u_tracker (.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
      .in_last(in_word.last), .word_pos(word_pos), .hdr_done(hdr_done));

   eth_parser u_eth (.clk(clk), .rst_n(rst_n), .in_data(in_word.data), .word_pos(word_pos),
      .accept(in_accept), .mac_table(mac_table), .eth_result(eth_result));

   ip_header_checker u_ip (.clk(clk), .rst_n(rst_n), .in_data(in_word.data),
      .word_pos(word_pos), .accept(in_accept), .ip_result(ip_result));

   forward_ctrl u_ctrl (.clk(clk), .rst_n(rst_n), .pkt_head(pkt_head), .pkt_empty(pkt_empty),
      .pkt_rd(pkt_rd), .res_head(res_head), .res_empty(res_empty), .res_rd(res_rd),
      .out_pkt(out_pkt), .out_valid(out_valid), .out_ready(out_ready), .stats(stats));

   oplut_regs u_regs (.clk(clk), .rst_n(rst_n), .reg_req_valid(reg_req_valid), .reg_req(reg_req),
      .reg_ack(reg_ack), .reg_rsp(reg_rsp), .stats(stats), .mac_table(mac_table));

endmodule

/* pkt_pkg.sv */
`include "oplut_defs.svh"

package pkt_pkg;

   // one stream beat
   typedef struct packed {
      logic [`OPLUT_DATA_W-1:0] data;
      logic                     last;   // final word of the packet
   } pkt_word_t;

   // stream beat tagged with its egress port
   typedef struct packed {
      logic [`OPLUT_PORT_W-1:0] port;
      pkt_word_t                word;
   } out_pkt_t;

   // position of a word inside the header
   typedef enum logic [2:0] {
      HDR_W0,        // dst mac, src mac hi
      HDR_W1,        // src mac lo, ethertype, ver/ihl, tos
      HDR_W2,        // len, id, frag, ttl, proto
      HDR_W3,        // checksum, src ip, dst ip hi
      HDR_W4,        // dst ip lo, payload
      HDR_PAYLOAD
   } hdr_word_e;

   typedef struct packed {
      logic                     mac_hit;
      logic [`OPLUT_PORT_W-1:0] port;     // lowest matching table index
      logic                     is_ip;
   } eth_result_t;

   typedef struct packed {
      logic        hdr_good;              // version, ihl and checksum all fine
      logic        ttl_good;
      logic [15:0] new_checksum;          // checksum after ttl decrement
   } ip_result_t;

   // one entry per packet in the result fifo
   typedef struct packed {
      eth_result_t eth;
      ip_result_t  ip;
   } lookup_result_t;

   typedef enum logic [2:0] {
      VERDICT_FWD,
      VERDICT_DROP_MAC,
      VERDICT_DROP_NON_IP,
      VERDICT_DROP_HDR,
      VERDICT_DROP_TTL
   } verdict_e;

endpackage

/* regs_pkg.sv */
`include "oplut_defs.svh"

package regs_pkg;

   // single cycle request from the host
   typedef struct packed {
      logic                         wr;     // 1 write, 0 read
      logic [`OPLUT_REG_ADDR_W-1:0] addr;
      logic [31:0]                  data;
   } reg_req_t;

   typedef struct packed {
      logic [31:0] rd_data;   // valid with reg_ack only
   } reg_rsp_t;

   // one 48 bit address per port
   typedef logic [`OPLUT_NUM_PORTS-1:0][47:0] mac_table_t;

   // one cycle event strobes from the forwarding FSM
   typedef struct packed {
      logic forwarded;
      logic drop_hdr;
      logic drop_other;
   } stats_pulse_t;

endpackage

/* sync_fifo.sv */
module sync_fifo #(
   parameter int WIDTH      = 8,
   parameter int DEPTH_BITS = 3
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic [WIDTH-1:0] wr_data,
   input  logic             wr_en,
   input  logic             rd_en,
   output logic [WIDTH-1:0] rd_data,
   output logic             empty,
   output logic             nearly_full
);
   localparam int DEPTH = 1 << DEPTH_BITS;

   logic [WIDTH-1:0]      mem [DEPTH];
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;       // one extra bit to hold DEPTH
   logic                  do_wr;
   logic                  do_rd;

   assign do_wr = wr_en && (count != DEPTH[DEPTH_BITS:0]);   // full writes are lost
   assign do_rd = rd_en && !empty;

   assign rd_data     = mem[rd_ptr];                        // head shows without a read
   assign empty       = (count == '0);
   assign nearly_full = (count >= DEPTH[DEPTH_BITS:0] - 2'd2);

   always_ff @(posedge clk) begin
      if (do_wr) mem[wr_ptr] <= wr_data;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;   // pointers wrap naturally
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         count <= count + do_wr - do_rd;
      end
   end

endmodule

/* tb.f */
+incdir+.
pkt_pkg.sv
regs_pkg.sv
sync_fifo.sv
hdr_word_tracker.sv
eth_parser.sv
ip_header_checker.sv
forward_ctrl.sv
oplut_regs.sv
output_port_lookup.sv
tb_output_port_lookup.sv

/* tb_output_port_lookup.sv */
`include "oplut_defs.svh"

module tb_output_port_lookup;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int WAIT_LIMIT  = 400;    // cycles before a stalled wait gives up
   localparam int ACK_LIMIT   = 4;
   localparam int MIXED_LIMIT = 3000;

   logic                   clk;
   logic                   rst_n;
   pkt_pkg::pkt_word_t     in_word;
   logic                   in_valid;
   logic                   in_ready;
   pkt_pkg::out_pkt_t      out_pkt;
   logic                   out_valid;
   logic                   out_ready;
   logic                   reg_req_valid;
   regs_pkg::reg_req_t     reg_req;
   logic                   reg_ack;
   regs_pkg::reg_rsp_t     reg_rsp;

   logic [31:0]            lcg_state;
   logic [47:0]            port_mac [4];
   logic [63:0]            pkt_w [16];     // packet being built
   int                     pkt_n;
   pkt_pkg::pkt_word_t     stim_q [$];     // words waiting to be driven
   pkt_pkg::out_pkt_t      exp_q [$];      // words the DUT still owes us
   int                     n_fwd;
   int                     n_hdr;
   int                     n_other;

   output_port_lookup UUT (
      .clk(clk), .rst_n(rst_n), .in_word(in_word), .in_valid(in_valid), .in_ready(in_ready),
      .out_pkt(out_pkt), .out_valid(out_valid), .out_ready(out_ready),
      .reg_req_valid(reg_req_valid), .reg_req(reg_req), .reg_ack(reg_ack), .reg_rsp(reg_rsp));

   always #20 clk = ~clk;   // 40 ns period

   // ========================================
   // helpers
   // ========================================
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // rfc 791 checksum over the nine fields without the checksum slot
   function automatic logic [15:0] hdr_csum(input logic [63:0] w1, w2, w3, w4);
      logic [15:0] f [9];
      logic [31:0] s;
      f = '{w1[15:0], w2[63:48], w2[47:32], w2[31:16], w2[15:0],
            w3[47:32], w3[31:16], w3[15:0], w4[63:48]};
      s = '0;
      for (int i = 0; i < 9; i++) begin
         s = s + 32'(f[i]);
      end
      while (s[31:16] != 16'h0) begin
         s = 32'(s[15:0]) + 32'(s[31:16]);   // end-around carry
      end
      return ~s[15:0];
   endfunction

   task automatic report_failure();
      $display("TEST RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [66:0] got, input logic [66:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
         report_failure();
      end
   endtask

   task automatic wait_reg_ack();
      int n;
      n = 0;
      while (!reg_ack) begin
         if (n == ACK_LIMIT) begin
            $display("register request was never acknowledged");
            report_failure();
         end
         @(posedge clk);
         #2;
         n++;
      end
      check_value("reg_ack_delay", 67'(n), 67'(0));   // ack due in the cycle after the request
   endtask

   task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
      reg_req       = '{wr: 1'b1, addr: addr, data: data};
      reg_req_valid = 1'b1;
      @(posedge clk);
      #2;
      reg_req_valid = 1'b0;   // single cycle pulse
      wait_reg_ack();
   endtask

   task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
      reg_req       = '{wr: 1'b0, addr: addr, data: 32'h0};
      reg_req_valid = 1'b1;
      @(posedge clk);
      #2;
      reg_req_valid = 1'b0;
      wait_reg_ack();
      data = reg_rsp.rd_data;   // valid in the ack cycle
   endtask

   task automatic check_register(input logic [3:0] addr, input string name,
                                 input logic [31:0] exp);
      logic [31:0] v;
      reg_read(addr, v);
      check_value(name, 67'(v), 67'(exp));
   endtask

   // counters settle some cycles after the packet so poll until they do
   task automatic wait_counter(input logic [3:0] addr, input string name,
                               input logic [31:0] exp);
      logic [31:0] v;
      int          n;
      n = 0;
      reg_read(addr, v);
      while (v != exp && n < WAIT_LIMIT) begin
         reg_read(addr, v);
         n++;
      end
      check_value(name, 67'(v), 67'(exp));
   endtask

   task automatic build_packet(input logic [47:0] dst, input logic [15:0] etype,
                               input logic [7:0] ver_ihl, input logic [7:0] ttl,
                               input bit corrupt, input int nwords);
      logic [31:0]        r0, r1, r2, r3;
      logic [15:0]        csum;
      pkt_pkg::pkt_word_t w;
      r0 = next_rand();
      r1 = next_rand();
      r2 = next_rand();
      r3 = next_rand();
      pkt_n    = nwords;
      pkt_w[0] = {dst, r0[15:0]};                                      // src mac hi
      pkt_w[1] = {r1, etype, ver_ihl, 8'h00};                          // tos 0
      pkt_w[2] = {16'(nwords * 8), r2[15:0], 16'h4000, ttl, 8'h11};    // df set and udp
      pkt_w[3] = {16'h0000, r3, r0[31:16]};                            // src ip, dst ip hi
      pkt_w[4] = {r2[31:16], 48'h0};
      for (int i = 4; i < nwords; i++) begin
         r0 = next_rand();
         r1 = next_rand();
         if (i == 4) pkt_w[4][47:0] = {r0[15:0], r1};
         else pkt_w[i] = {r0, r1};
      end
      csum = hdr_csum(pkt_w[1], pkt_w[2], pkt_w[3], pkt_w[4]);
      pkt_w[3][63:48] = corrupt ? (csum ^ 16'h0100) : csum;
      for (int i = 0; i < nwords; i++) begin
         w.data = pkt_w[i];
         w.last = (i == nwords - 1);
         stim_q.push_back(w);
      end
   endtask

   // reference for a forwarded copy of the last built packet
   task automatic expect_packet(input logic [1:0] port);
      logic [63:0]       d;
      logic [63:0]       w2;
      pkt_pkg::out_pkt_t o;
      w2       = pkt_w[2];
      w2[15:8] = w2[15:8] - 8'd1;   // ttl
      for (int i = 0; i < pkt_n; i++) begin
         d = pkt_w[i];
         if (i == 2) d = w2;
         if (i == 3) d[63:48] = hdr_csum(pkt_w[1], w2, pkt_w[3], pkt_w[4]);
         o.port      = port;
         o.word.data = d;
         o.word.last = (i == pkt_n - 1);
         exp_q.push_back(o);
      end
      n_fwd++;
   endtask

   task automatic send_stimulus();
      int n;
      while (stim_q.size() != 0) begin
         in_word  = stim_q.pop_front();
         in_valid = 1'b1;
         n = 0;
         while (!in_ready) begin
            if (n == WAIT_LIMIT) begin
               $display("input stream stalled, in_ready stayed low");
               report_failure();
            end
            @(posedge clk);
            #2;
            n++;
         end
         @(posedge clk);   // word accepted on this edge
         #2;
      end
      in_valid = 1'b0;
      in_word  = '0;
   endtask

   task automatic wait_output_drained();
      int n;
      n = 0;
      while (exp_q.size() != 0) begin
         if (n == WAIT_LIMIT) begin
            $display("timeout, %0d expected output words never came out", exp_q.size());
            report_failure();
         end
         @(posedge clk);
         #2;
         n++;
      end
   endtask

   // output monitor samples mid cycle where everything is stable
   always @(negedge clk) begin
      if (rst_n && out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            $display("DUT sent a word nobody expected: %h", out_pkt);
            report_failure();
         end else begin
            check_value("out_pkt", 67'(out_pkt), 67'(exp_q.pop_front()));
         end
      end
   end

   // ========================================
   // tests
   // ========================================
   task automatic test_registers();
      for (int i = 0; i < 8; i++) begin
         check_register(4'(i), $sformatf("mac_reg%0d", i), 32'h0);   // table clears on reset
      end
      for (int i = 0; i < 4; i++) begin
         reg_write(4'(2 * i), {16'h0, port_mac[i][47:32]});
         reg_write(4'(2 * i + 1), port_mac[i][31:0]);
      end
      for (int i = 0; i < 4; i++) begin
         check_register(4'(2 * i), $sformatf("mac%0d_hi", i), {16'h0, port_mac[i][47:32]});
         check_register(4'(2 * i + 1), $sformatf("mac%0d_lo", i), port_mac[i][31:0]);
      end
      check_register(`OPLUT_REG_FORWARDED, "forwarded", 0);
      check_register(`OPLUT_REG_DROP_HDR, "drop_hdr", 0);
      check_register(`OPLUT_REG_DROP_OTHER, "drop_other", 0);
      reg_write(`OPLUT_REG_FORWARDED, 32'h0000_1234);   // read only so the write must not stick
      check_register(`OPLUT_REG_FORWARDED, "forwarded", 0);
      check_register(4'd12, "unmapped", 0);
   endtask

   task automatic test_forward();
      build_packet(port_mac[2], `OPLUT_ETHERTYPE_IP, 8'h45, 8'd64, 1'b0, 8);
      expect_packet(2'd2);
      send_stimulus();
      wait_output_drained();
      wait_counter(`OPLUT_REG_FORWARDED, "forwarded", n_fwd);
   endtask

   task automatic test_header_drops();
      build_packet(port_mac[1], `OPLUT_ETHERTYPE_IP, 8'h45, 8'd64, 1'b1, 6);   // bad csum
      build_packet(port_mac[0], `OPLUT_ETHERTYPE_IP, 8'h46, 8'd64, 1'b0, 7);   // options
      n_hdr += 2;
      send_stimulus();
      wait_counter(`OPLUT_REG_DROP_HDR, "drop_hdr", n_hdr);
      check_register(`OPLUT_REG_FORWARDED, "forwarded", n_fwd);
      check_register(`OPLUT_REG_DROP_OTHER, "drop_other", n_other);
   endtask

   task automatic test_other_drops();
      build_packet(48'h02_1a_2b_3c_4d_ee, `OPLUT_ETHERTYPE_IP, 8'h45, 8'd64, 1'b0, 6);
      build_packet(port_mac[3], 16'h0806, 8'h45, 8'd64, 1'b0, 6);   // arp
      build_packet(port_mac[3], `OPLUT_ETHERTYPE_IP, 8'h45, 8'd1, 1'b0, 6);
      n_other += 3;
      send_stimulus();
      wait_counter(`OPLUT_REG_DROP_OTHER, "drop_other", n_other);

      // an all ones table entry still may not claim a broadcast frame
      reg_write(`OPLUT_REG_MAC3_HI, 32'h0000_ffff);
      reg_write(`OPLUT_REG_MAC3_LO, 32'hffff_ffff);
      build_packet(48'hff_ff_ff_ff_ff_ff, `OPLUT_ETHERTYPE_IP, 8'h45, 8'd64, 1'b0, 6);
      n_other++;
      send_stimulus();
      wait_counter(`OPLUT_REG_DROP_OTHER, "drop_other", n_other);
      reg_write(`OPLUT_REG_MAC3_HI, {16'h0, port_mac[3][47:32]});
      reg_write(`OPLUT_REG_MAC3_LO, port_mac[3][31:0]);

      check_register(`OPLUT_REG_DROP_HDR, "drop_hdr", n_hdr);
      check_register(`OPLUT_REG_FORWARDED, "forwarded", n_fwd);
   endtask

   task automatic test_mixed_traffic();
      logic [31:0] r;
      int          kind;
      int          len;
      int          n;
      bit          sent;
      for (int p = 0; p < 12; p++) begin
         r    = next_rand();
         kind = int'(r >> 29);                 // upper lcg bits are the good ones
         len  = 6 + int'(r[28:26]) % 5;
         case (kind)
            0, 1, 2: begin
               build_packet(port_mac[r[25:24]], `OPLUT_ETHERTYPE_IP, 8'h45, 8'd9, 1'b0, len);
               expect_packet(r[25:24]);
            end
            3: build_packet(port_mac[0], `OPLUT_ETHERTYPE_IP, 8'h45, 8'd9, 1'b1, len);
            4: build_packet(port_mac[1], `OPLUT_ETHERTYPE_IP, 8'h4f, 8'd9, 1'b0, len);
            5: build_packet(48'h02_1a_2b_3c_4d_ee, `OPLUT_ETHERTYPE_IP, 8'h45, 8'd9, 1'b0, len);
            6: build_packet(port_mac[2], 16'h86dd, 8'h45, 8'd9, 1'b0, len);   // ipv6
            default: build_packet(port_mac[3], `OPLUT_ETHERTYPE_IP, 8'h45, 8'(r[0]), 1'b0, len);
         endcase
         if (kind == 3 || kind == 4) n_hdr++;
         else if (kind > 4) n_other++;
      end
      sent = 1'b0;
      fork
         begin
            send_stimulus();
            sent = 1'b1;
         end
         begin
            n = 0;
            while (!(sent && exp_q.size() == 0)) begin
               if (n == MIXED_LIMIT) begin
                  $display("mixed traffic did not finish, %0d words missing", exp_q.size());
                  report_failure();
               end
               r         = next_rand();
               out_ready = r[31];               // random back-pressure
               @(posedge clk);
               #2;
               n++;
            end
            out_ready = 1'b1;
         end
      join
      wait_counter(`OPLUT_REG_FORWARDED, "forwarded", n_fwd);
      wait_counter(`OPLUT_REG_DROP_HDR, "drop_hdr", n_hdr);
      wait_counter(`OPLUT_REG_DROP_OTHER, "drop_other", n_other);
   endtask

   // ========================================
   // main sequence
   // ========================================
   initial begin
      clk           = 1'b0;
      rst_n         = 1'b0;
      in_word       = '0;
      in_valid      = 1'b0;
      out_ready     = 1'b0;
      reg_req_valid = 1'b0;
      reg_req       = '0;
      lcg_state     = 32'hdeca5ecb;
      n_fwd         = 0;
      n_hdr         = 0;
      n_other       = 0;
      port_mac[0]   = 48'h02_1a_2b_3c_4d_10;   // locally administered unicast
      port_mac[1]   = 48'h02_1a_2b_3c_4d_21;
      port_mac[2]   = 48'h02_1a_2b_3c_4d_32;
      port_mac[3]   = 48'h02_1a_2b_3c_4d_43;
      repeat (4) @(posedge clk);
      #2;
      rst_n = 1'b1;
      check_value("out_valid", 67'(out_valid), 67'(0));
      check_value("reg_ack", 67'(reg_ack), 67'(0));
      check_value("in_ready", 67'(in_ready), 67'(1));   // empty buffer takes words
      out_ready = 1'b1;

      test_registers();
      test_forward();
      test_header_drops();
      test_other_drops();
      test_mixed_traffic();

      if (exp_q.size() == 0) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         $display("%0d expected output words were never sent", exp_q.size());
         report_failure();
      end
   end

endmodule
